// ==== filelist.f ====
hw/mcu_cmd_pkg.sv
hw/mcu_cmd_decode.sv
hw/mcu_cfg_regs.sv
hw/mcu_addr_ctr.sv
hw/mcu_mem_req.sv
hw/mcu_readback.sv
hw/mcu_cmd_top.sv
tests/mcu_cmd_tb.sv

// ==== hw/mcu_addr_ctr.sv ====
`timescale 1ns/10ps
`default_nettype none

module mcu_addr_ctr import mcu_cmd_pkg::*; (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       addr_load,
  input  wire logic [1:0] addr_byte,
  input  byte_t           data,
  input  wire logic       addr_inc,
  output addr_t           addr
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr <= '0;
    end else if (addr_load) begin
      // top byte starts a fresh address
      if (addr_byte == 2'd0) begin
        addr <= {data, 16'h0000};
      end else begin
        addr <= put_byte(addr, addr_byte, data);
      end
    end else if (addr_inc) begin
      addr <= addr + addr_t'(1);
    end
  end

  // an address load during a pending memory access is a protocol error
  a_load_vs_inc: assert property (@(posedge clk) disable iff (!rst_n)
    !(addr_load && addr_inc));

endmodule

`default_nettype wire

// ==== hw/mcu_cfg_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module mcu_cfg_regs import mcu_cmd_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_n,
  input  cfg_wr_t   cfg_wr,
  output cfg_t      cfg
);

  byte_t feat_hold;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg.mapper      <= MAPPER_RESET;
      cfg.rom_mask    <= '0;
      cfg.sram_mask   <= '0;
      cfg.region      <= 1'b0;
      cfg.featurebits <= '0;
    end else begin
      case (cfg_wr.field)
        CFG_MAPPER:    cfg.mapper <= cfg_wr.data[2:0];
        CFG_ROM_MASK:  cfg.rom_mask <= put_byte(cfg.rom_mask, cfg_wr.byte_sel, cfg_wr.data);
        CFG_SRAM_MASK: cfg.sram_mask <= put_byte(cfg.sram_mask, cfg_wr.byte_sel, cfg_wr.data);
        CFG_REGION:    cfg.region <= cfg_wr.data[0];
        CFG_FEAT: begin
          // low byte commits both halves at once
          if (cfg_wr.byte_sel == 2'd1) begin
            cfg.featurebits <= {feat_hold, cfg_wr.data};
          end
        end
        default: ;
      endcase
    end
  end

  // high feature byte waits here
  always_ff @(posedge clk) begin
    if (cfg_wr.field == CFG_FEAT && cfg_wr.byte_sel == 2'd0) begin
      feat_hold <= cfg_wr.data;
    end
  end

endmodule

`default_nettype wire

// ==== hw/mcu_cmd_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module mcu_cmd_decode import mcu_cmd_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_n,
  input  spi_in_t   spi,
  input  wire logic mem_done,
  output cfg_wr_t   cfg_wr,
  output logic      addr_load,
  output logic [1:0] addr_byte,
  output logic      addr_inc,
  output logic      rd_start,
  output logic      wr_start,
  output byte_t     wr_data,
  output logic      rb_load,
  output rb_src_e   rb_src
);

  typedef enum logic [3:0] {
    GRP_NONE,
    GRP_ADDR,
    GRP_ROM_MASK,
    GRP_SRAM_MASK,
    GRP_MAPPER,
    GRP_READ,
    GRP_WRITE,
    GRP_FEAT,
    GRP_REGION,
    GRP_MAGIC,
    GRP_ECHO
  } cmd_grp_e;

  cmd_grp_e   grp;
  logic [1:0] param_idx;
  logic       in_mask_range;
  logic       in_feat_range;
  logic       inc_cond;
  logic       rb_strobe;
  rb_src_e    rb_strobe_src;
  logic       rd_pend;
  logic       inc_pend;
  logic       rd_done;

  //////////////////////////////////////////////////
  // command group
  always_comb begin
    grp = GRP_NONE;
    if (spi.cmd_data == CMD_ADDR) begin
      grp = GRP_ADDR;
    end else if (spi.cmd_data == CMD_FEAT) begin
      grp = GRP_FEAT;
    end else if (spi.cmd_data == CMD_REGION) begin
      grp = GRP_REGION;
    end else if (spi.cmd_data == CMD_MAGIC) begin
      grp = GRP_MAGIC;
    end else if (spi.cmd_data == CMD_ECHO) begin
      grp = GRP_ECHO;
    end else begin
      case (spi.cmd_data[7:4])
        OP_ROM_MASK:  grp = GRP_ROM_MASK;
        OP_SRAM_MASK: grp = GRP_SRAM_MASK;
        OP_MAPPER:    grp = GRP_MAPPER;
        OP_READ:      grp = GRP_READ;
        OP_WRITE:     grp = GRP_WRITE;
        default:      grp = GRP_NONE;
      endcase
    end
  end

  // first parameter is byte 2
  assign param_idx     = 2'(spi.byte_cnt - byte_cnt_t'(2));
  assign in_mask_range = (spi.byte_cnt >= byte_cnt_t'(2)) && (spi.byte_cnt <= byte_cnt_t'(4));
  assign in_feat_range = (spi.byte_cnt >= byte_cnt_t'(2)) && (spi.byte_cnt <= byte_cnt_t'(3));

  // bit 3 enables auto-increment and bit 4 skips it on the command byte
  assign inc_cond = spi.cmd_data[3]
                    && (spi.byte_cnt >= byte_cnt_t'(1) + byte_cnt_t'(spi.cmd_data[4]));

  //////////////////////////////////////////////////
  // strobe to action
  always_comb begin
    cfg_wr        = '{field: CFG_NONE, byte_sel: param_idx, data: spi.param_data};
    addr_load     = 1'b0;
    rd_start      = 1'b0;
    wr_start      = 1'b0;
    rb_strobe     = 1'b0;
    rb_strobe_src = RB_CONST_A5;
    if (spi.cmd_ready) begin
      case (grp)
        GRP_MAPPER: begin
          cfg_wr.field    = CFG_MAPPER;
          cfg_wr.byte_sel = 2'd0;
          cfg_wr.data     = spi.cmd_data;
        end
        GRP_READ:  rd_start  = 1'b1;
        GRP_MAGIC: rb_strobe = 1'b1;
        default: ;
      endcase
    end else if (spi.param_ready) begin
      case (grp)
        GRP_ADDR:      addr_load = in_mask_range;
        GRP_ROM_MASK:  if (in_mask_range) cfg_wr.field = CFG_ROM_MASK;
        GRP_SRAM_MASK: if (in_mask_range) cfg_wr.field = CFG_SRAM_MASK;
        GRP_FEAT:      if (in_feat_range) cfg_wr.field = CFG_FEAT;
        GRP_REGION:    cfg_wr.field = CFG_REGION;
        GRP_READ:      rd_start = 1'b1;
        GRP_WRITE:     wr_start = 1'b1;
        GRP_MAGIC:     rb_strobe = 1'b1;
        GRP_ECHO: begin
          rb_strobe     = 1'b1;
          rb_strobe_src = RB_ECHO;
        end
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // outstanding memory access
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pend  <= 1'b0;
      inc_pend <= 1'b0;
    end else if (rd_start || wr_start) begin
      rd_pend  <= rd_start;
      inc_pend <= inc_cond;
    end else if (mem_done) begin
      rd_pend  <= 1'b0;
      inc_pend <= 1'b0;
    end
  end

  assign rd_done   = mem_done && rd_pend;
  assign addr_inc  = mem_done && inc_pend;
  assign addr_byte = param_idx;
  assign wr_data   = spi.param_data;

  // read data wins over a readback strobe
  assign rb_load = rd_done || rb_strobe;
  assign rb_src  = rd_done ? RB_MEM : rb_strobe_src;

  a_one_start: assert property (@(posedge clk) disable iff (!rst_n)
    !(rd_start && wr_start));

endmodule

`default_nettype wire

// ==== hw/mcu_cmd_pkg.sv ====
`default_nettype none

package mcu_cmd_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [23:0] addr_t;
  typedef logic [31:0] byte_cnt_t;
  typedef logic [2:0]  mapper_t;
  typedef logic [15:0] feat_t;

  // command opcodes as full bytes or upper nibbles
  localparam byte_t      CMD_ADDR      = 8'h00;
  localparam logic [3:0] OP_ROM_MASK   = 4'h1;
  localparam logic [3:0] OP_SRAM_MASK  = 4'h2;
  localparam logic [3:0] OP_MAPPER     = 4'h3;
  localparam logic [3:0] OP_READ       = 4'h8;
  localparam logic [3:0] OP_WRITE      = 4'h9;
  localparam byte_t      CMD_FEAT      = 8'hED;
  localparam byte_t      CMD_REGION    = 8'hEE;
  localparam byte_t      CMD_MAGIC     = 8'hF0;
  localparam byte_t      CMD_ECHO      = 8'hFF;

  localparam mapper_t MAPPER_RESET = 3'd1;
  localparam byte_t   RB_MAGIC     = 8'hA5;

  typedef struct packed {
    logic      cmd_ready;
    logic      param_ready;
    byte_t     cmd_data;
    byte_t     param_data;
    byte_cnt_t byte_cnt;
  } spi_in_t;

  typedef enum logic [2:0] {
    CFG_NONE,
    CFG_MAPPER,
    CFG_ROM_MASK,
    CFG_SRAM_MASK,
    CFG_FEAT,
    CFG_REGION
  } cfg_field_e;

  typedef struct packed {
    cfg_field_e field;
    logic [1:0] byte_sel;
    byte_t      data;
  } cfg_wr_t;

  typedef struct packed {
    mapper_t mapper;
    addr_t   rom_mask;
    addr_t   sram_mask;
    logic    region;
    feat_t   featurebits;
  } cfg_t;

  typedef enum logic [1:0] {
    RB_MEM,
    RB_CONST_A5,
    RB_ECHO
  } rb_src_e;

  // replace one byte of a 24-bit value where sel 0 is the top byte
  function automatic addr_t put_byte(addr_t val, logic [1:0] sel, byte_t data);
    addr_t res;
    res = val;
    case (sel)
      2'd0:    res[23:16] = data;
      2'd1:    res[15:8]  = data;
      2'd2:    res[7:0]   = data;
      default: res = val;
    endcase
    return res;
  endfunction

endpackage

`default_nettype wire

// ==== hw/mcu_cmd_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module mcu_cmd_top import mcu_cmd_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_n,
  input  spi_in_t   spi,
  input  wire logic mcu_rq_rdy,
  input  byte_t     mcu_data_in,
  output cfg_t      cfg,
  output addr_t     addr_out,
  output logic      mcu_rrq,
  output logic      mcu_wrq,
  output byte_t     mcu_data_out,
  output byte_t     spi_data_out
);

  cfg_wr_t    cfg_wr;
  logic       addr_load;
  logic [1:0] addr_byte;
  logic       addr_inc;
  logic       rd_start;
  logic       wr_start;
  byte_t      wr_data;
  logic       mem_done;
  logic       rb_load;
  rb_src_e    rb_src;

  //////////////////////////////////////////////////
  // control
  mcu_cmd_decode mcu_cmd_decode_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .spi       (spi),
    .mem_done  (mem_done),
    .cfg_wr    (cfg_wr),
    .addr_load (addr_load),
    .addr_byte (addr_byte),
    .addr_inc  (addr_inc),
    .rd_start  (rd_start),
    .wr_start  (wr_start),
    .wr_data   (wr_data),
    .rb_load   (rb_load),
    .rb_src    (rb_src)
  );

  //////////////////////////////////////////////////
  // datapath
  mcu_cfg_regs mcu_cfg_regs_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .cfg_wr (cfg_wr),
    .cfg    (cfg)
  );

  mcu_addr_ctr mcu_addr_ctr_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .addr_load (addr_load),
    .addr_byte (addr_byte),
    .data      (spi.param_data),
    .addr_inc  (addr_inc),
    .addr      (addr_out)
  );

  mcu_mem_req mcu_mem_req_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_start     (rd_start),
    .wr_start     (wr_start),
    .wr_data      (wr_data),
    .mcu_rq_rdy   (mcu_rq_rdy),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_data_out (mcu_data_out),
    .mem_done     (mem_done)
  );

  mcu_readback mcu_readback_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .rb_load      (rb_load),
    .rb_src       (rb_src),
    .mem_data     (mcu_data_in),
    .echo_data    (spi.param_data),
    .spi_data_out (spi_data_out)
  );

endmodule

`default_nettype wire

// ==== hw/mcu_mem_req.sv ====
`timescale 1ns/10ps
`default_nettype none

module mcu_mem_req import mcu_cmd_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic rd_start,
  input  wire logic wr_start,
  input  byte_t     wr_data,
  input  wire logic mcu_rq_rdy,
  output logic      mcu_rrq,
  output logic      mcu_wrq,
  output byte_t     mcu_data_out,
  output logic      mem_done
);

  // older sample in bit 1
  logic [1:0] rdy_hist;

  //////////////////////////////////////////////////
  // request pulses
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mcu_rrq <= 1'b0;
      mcu_wrq <= 1'b0;
    end else begin
      mcu_rrq <= rd_start;
      mcu_wrq <= wr_start;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_start) begin
      mcu_data_out <= wr_data;
    end
  end

  //////////////////////////////////////////////////
  // ready rising edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdy_hist <= 2'b00;
      mem_done <= 1'b0;
    end else begin
      rdy_hist <= {rdy_hist[0], mcu_rq_rdy};
      mem_done <= rdy_hist[0] && !rdy_hist[1];
    end
  end

  a_one_req: assert property (@(posedge clk) disable iff (!rst_n)
    !(mcu_rrq && mcu_wrq));

endmodule

`default_nettype wire

// ==== hw/mcu_readback.sv ====
`timescale 1ns/10ps
`default_nettype none

module mcu_readback import mcu_cmd_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic rb_load,
  input  rb_src_e   rb_src,
  input  byte_t     mem_data,
  input  byte_t     echo_data,
  output byte_t     spi_data_out
);

  // byte shifted out during the next SPI transfer
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      spi_data_out <= '0;
    end else if (rb_load) begin
      case (rb_src)
        RB_MEM:      spi_data_out <= mem_data;
        RB_CONST_A5: spi_data_out <= RB_MAGIC;
        RB_ECHO:     spi_data_out <= echo_data;
        default:     spi_data_out <= spi_data_out;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator and run; the exit status follows the testbench result
cd "$(dirname "$0")" &&
verilator --binary --assert --timing -f filelist.f --top-module mcu_cmd_tb -o mcu_cmd_sim &&
./obj_dir/mcu_cmd_sim | tee /dev/stderr | grep -xF '** PASS **' > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== tests/mcu_cmd_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mcu_cmd_tb import mcu_cmd_pkg::*; ();

  // kinds of check on the return byte or the memory model
  localparam logic [1:0] SPI_NONE = 2'd0;
  localparam logic [1:0] SPI_LIT  = 2'd1;
  localparam logic [1:0] SPI_MEM  = 2'd2;
  localparam logic [1:0] MEM_LIT  = 2'd3;

  // one SPI transfer with params[31:24] sent first
  typedef struct packed {
    byte_t       cmd;
    int          n_param;
    logic [31:0] params;
    cfg_t        exp_cfg;
    addr_t       exp_addr;
    logic [1:0]  spi_chk;
    byte_t       exp_spi;
    addr_t       spi_addr;
  } row_t;

  logic    clk = 1'b0;
  logic    rst_n;
  spi_in_t spi;
  logic    mcu_rq_rdy;
  byte_t   mcu_data_in;
  cfg_t    cfg;
  addr_t   addr_out;
  logic    mcu_rrq;
  logic    mcu_wrq;
  byte_t   mcu_data_out;
  byte_t   spi_data_out;

  byte_t mem [0:255];
  row_t  rows[$];
  int    errors = 0;
  int    cycles = 0;
  int    cycle_limit = 0;

  always #4 clk = ~clk;

  mcu_cmd_top mcu_cmd_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .spi          (spi),
    .mcu_rq_rdy   (mcu_rq_rdy),
    .mcu_data_in  (mcu_data_in),
    .cfg          (cfg),
    .addr_out     (addr_out),
    .mcu_rrq      (mcu_rrq),
    .mcu_wrq      (mcu_wrq),
    .mcu_data_out (mcu_data_out),
    .spi_data_out (spi_data_out)
  );

  //////////////////////////////////////////////////
  // memory model that answers after 1 to 6 cycles
  initial begin
    int    i;
    int    wait_cnt;
    byte_t req_addr;
    logic  req_wr;
    void'($urandom(32'h2394));
    for (i = 0; i < 256; i++) begin
      mem[i] = 8'($urandom);
    end
    mcu_rq_rdy  = 1'b0;
    mcu_data_in = 8'h00;
    wait_cnt    = 0;
    req_addr    = 8'h00;
    req_wr      = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst_n) begin
        mcu_rq_rdy = 1'b0;
        wait_cnt   = 0;
      end else if (mcu_rrq || mcu_wrq) begin
        mcu_rq_rdy = 1'b0;
        wait_cnt   = 1 + int'($urandom % 6);
        req_addr   = addr_out[7:0];
        req_wr     = mcu_wrq;
      end else if (wait_cnt != 0) begin
        wait_cnt--;
        if (wait_cnt == 0) begin
          if (req_wr) begin
            mem[req_addr] = mcu_data_out;
          end
          mcu_data_in = mem[req_addr];
          mcu_rq_rdy  = 1'b1;
        end
      end
    end
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      $display("timeout: no result after %0d cycles", cycles);
      $display("errors: %0d", errors);
      $display("** FAIL **");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // helpers
  function automatic void flag_mismatch(string msg);
    errors++;
    $display("MISMATCH at %0t: %s", $time, msg);
  endfunction

  task automatic add_row(byte_t cmd, int n, logic [31:0] p, cfg_t c, addr_t a,
                         logic [1:0] chk, byte_t s, addr_t sa);
    rows.push_back('{cmd: cmd, n_param: n, params: p, exp_cfg: c, exp_addr: a,
                     spi_chk: chk, exp_spi: s, spi_addr: sa});
  endtask

  // strobe one byte, then leave room for the slowest memory answer
  task automatic send_byte(logic is_cmd, byte_t cmd, byte_t data, int cnt);
    @(negedge clk);
    spi.cmd_ready   = is_cmd;
    spi.param_ready = !is_cmd;
    spi.cmd_data    = cmd;
    spi.param_data  = data;
    spi.byte_cnt    = byte_cnt_t'(cnt);
    @(negedge clk);
    spi.cmd_ready   = 1'b0;
    spi.param_ready = 1'b0;
    repeat (14) @(negedge clk);
  endtask

  task automatic run_transfer(row_t r);
    int k;
    send_byte(1'b1, r.cmd, 8'h00, 1);
    for (k = 0; k < r.n_param; k++) begin
      send_byte(1'b0, r.cmd, r.params[31 - 8 * k -: 8], k + 2);
    end
  endtask

  task automatic check_row(row_t r);
    assert (cfg == r.exp_cfg)
      else flag_mismatch($sformatf("cmd %02h cfg %h, expected %h", r.cmd, cfg, r.exp_cfg));
    assert (addr_out == r.exp_addr)
      else flag_mismatch($sformatf("cmd %02h addr_out %06h, expected %06h",
                                   r.cmd, addr_out, r.exp_addr));
    assert (!mcu_rrq && !mcu_wrq)
      else flag_mismatch($sformatf("cmd %02h request still high", r.cmd));
    case (r.spi_chk)
      SPI_LIT: assert (spi_data_out == r.exp_spi)
        else flag_mismatch($sformatf("cmd %02h spi_data_out %02h, expected %02h",
                                     r.cmd, spi_data_out, r.exp_spi));
      SPI_MEM: assert (spi_data_out == mem[r.spi_addr[7:0]])
        else flag_mismatch($sformatf("cmd %02h spi_data_out %02h, expected %02h",
                                     r.cmd, spi_data_out, mem[r.spi_addr[7:0]]));
      MEM_LIT: assert (mem[r.spi_addr[7:0]] == r.exp_spi)
        else flag_mismatch($sformatf("cmd %02h memory byte %02h, expected %02h",
                                     r.cmd, mem[r.spi_addr[7:0]], r.exp_spi));
      default: ;
    endcase
  endtask

  //////////////////////////////////////////////////
  // stimulus table and main sequence
  initial begin
    cfg_t  c;
    addr_t a;
    int    i;
    rst_n = 1'b0;
    spi   = '0;
    c     = '0;
    a     = '0;

    c.mapper = 3'd5;
    add_row(8'h35, 0, 32'h0, c, a, SPI_NONE, 8'h00, 24'h0);
    c.rom_mask = 24'h3FFFFF;
    add_row(8'h12, 3, 32'h3FFFFF00, c, a, SPI_NONE, 8'h00, 24'h0);
    c.sram_mask = 24'h001FFF;
    add_row(8'h20, 3, 32'h001FFF00, c, a, SPI_NONE, 8'h00, 24'h0);
    c.featurebits = 16'h1234;
    add_row(8'hED, 2, 32'h12340000, c, a, SPI_NONE, 8'h00, 24'h0);
    c.region = 1'b1;
    add_row(8'hEE, 1, 32'h01000000, c, a, SPI_NONE, 8'h00, 24'h0);
    a = 24'h7E1240;
    add_row(8'h00, 3, 32'h7E124000, c, a, SPI_NONE, 8'h00, 24'h0);
    // four reads, command byte included
    a = 24'h7E1244;
    add_row(8'h88, 3, 32'h0, c, a, SPI_MEM, 8'h00, 24'h7E1243);
    add_row(8'h80, 2, 32'h0, c, a, SPI_MEM, 8'h00, 24'h7E1244);
    a = 24'h550000;
    add_row(8'h00, 1, 32'h55000000, c, a, SPI_NONE, 8'h00, 24'h0);
    a = 24'h0000C0;
    add_row(8'h00, 3, 32'h0000C000, c, a, SPI_NONE, 8'h00, 24'h0);
    a = 24'h0000C4;
    add_row(8'h98, 4, 32'hDEADBEEF, c, a, MEM_LIT, 8'hEF, 24'h0000C3);
    a = 24'h0000C0;
    add_row(8'h00, 3, 32'h0000C000, c, a, SPI_NONE, 8'h00, 24'h0);
    add_row(8'h88, 0, 32'h0, c, 24'h0000C1, SPI_LIT, 8'hDE, 24'h0);
    add_row(8'h88, 0, 32'h0, c, 24'h0000C2, SPI_LIT, 8'hAD, 24'h0);
    add_row(8'h88, 0, 32'h0, c, 24'h0000C3, SPI_LIT, 8'hBE, 24'h0);
    a = 24'h0000C4;
    add_row(8'h88, 0, 32'h0, c, a, SPI_LIT, 8'hEF, 24'h0);
    add_row(8'hF0, 0, 32'h0, c, a, SPI_LIT, 8'hA5, 24'h0);
    add_row(8'hFF, 1, 32'h3C000000, c, a, SPI_LIT, 8'h3C, 24'h0);
    c.region = 1'b0;
    add_row(8'hEE, 1, 32'h02000000, c, a, SPI_NONE, 8'h00, 24'h0);
    c.mapper = 3'd2;
    add_row(8'h3A, 0, 32'h0, c, a, SPI_NONE, 8'h00, 24'h0);

    cycle_limit = rows.size() * 5 * 16 + 100;

    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    // reset state
    c = '0;
    c.mapper = 3'd1;
    assert (cfg == c)
      else flag_mismatch($sformatf("reset cfg %h, expected %h", cfg, c));
    assert (addr_out == 24'h0)
      else flag_mismatch($sformatf("reset addr_out %06h, expected 0", addr_out));
    assert (!mcu_rrq && !mcu_wrq)
      else flag_mismatch("reset request lines not low");
    assert (spi_data_out == 8'h00)
      else flag_mismatch($sformatf("reset spi_data_out %02h, expected 0", spi_data_out));

    for (i = 0; i < rows.size(); i++) begin
      run_transfer(rows[i]);
      check_row(rows[i]);
    end

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
